// File: pipe_core.f
source/core_pkg.sv
source/fetch_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/pipe_core_top.sv
testbench/pipe_core_tb.sv

// File: Bender.yml
package:
  name: pipe_core

sources:
  - source/core_pkg.sv
  - source/fetch_unit.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/result_stage.sv
  - source/pipe_core_top.sv
  - target: simulation
    files:
      - testbench/pipe_core_tb.sv

// File: testbench/pipe_core_tb.sv
`timescale 1ns/1ps

module pipe_core_tb
    import core_pkg::*;
();

    logic            aclk;
    logic            reset;
    logic            imem_ack;
    logic [xlen-1:0] imem_rdata;
    logic            imem_req;
    logic [xlen-1:0] imem_addr;
    trace_t          trace;

    logic [xlen-1:0]       program_mem [$];
    logic [xlen-1:0]       exp_pc [$];
    logic [reg_addr_w-1:0] exp_rd [$];
    logic [xlen-1:0]       exp_val [$];
    int                    exp_count;
    int                    exp_idx;
    int                    cycle_count;
    int                    cycle_limit;
    logic [31:0]           rng_state;
    logic                  prev_req;
    logic                  prev_ack;
    logic [xlen-1:0]       prev_addr;

    pipe_core_top i_pipe_core_top (
        .aclk       (aclk),
        .reset      (reset),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .trace      (trace)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] encode(opcode_e op, int rd, int rj, int rk, int imm);
        return {op, 5'(rd), 5'(rj), 5'(rk), 13'(imm)};
    endfunction

    // addi to r30 outside the program so a stray fetch lands in the trace
    function automatic logic [31:0] fetch_word(logic [xlen-1:0] addr);
        logic [xlen-1:0] idx;
        idx = addr >> 2;
        if (addr[1:0] == 2'b00 && idx < program_mem.size()) begin
            return program_mem[idx];
        end
        return encode(op_addi, 30, 0, 0, int'(addr ^ (addr >> 13) ^ (addr >> 26)));
    endfunction

    task automatic load_program();
        program_mem.push_back(encode(op_addi, 1, 0, 0, 5));
        program_mem.push_back(encode(op_addi, 2, 0, 0, -3));
        program_mem.push_back(encode(op_add, 3, 1, 2, 0));
        program_mem.push_back(encode(op_sub, 4, 3, 1, 0));
        program_mem.push_back(encode(op_and, 5, 4, 1, 0));
        program_mem.push_back(encode(op_or, 6, 5, 2, 0));
        program_mem.push_back(encode(op_xor, 7, 6, 3, 0));
        program_mem.push_back(encode(op_slt, 8, 2, 1, 0));
        program_mem.push_back(encode(op_slt, 9, 1, 2, 0));
        program_mem.push_back(encode(op_lui, 10, 0, 0, 'h1abc));
        program_mem.push_back(encode(op_addi, 10, 10, 0, 17));
        // r0 write then r0 read
        program_mem.push_back(encode(op_addi, 0, 1, 0, 7));
        program_mem.push_back(encode(op_add, 11, 0, 1, 0));
        // taken branches over dead code
        program_mem.push_back(encode(op_beq, 0, 1, 1, 3));
        program_mem.push_back(encode(op_addi, 12, 0, 0, 99));
        program_mem.push_back(encode(op_addi, 13, 0, 0, 98));
        program_mem.push_back(encode(op_bne, 0, 1, 2, 2));
        program_mem.push_back(encode(op_addi, 14, 0, 0, 77));
        // not taken
        program_mem.push_back(encode(op_beq, 0, 1, 2, 5));
        program_mem.push_back(encode(op_bne, 0, 1, 1, 5));
        // small countdown loop
        program_mem.push_back(encode(op_addi, 16, 0, 0, 3));
        program_mem.push_back(encode(op_addi, 15, 0, 0, 0));
        program_mem.push_back(encode(op_addi, 15, 15, 0, 2));
        program_mem.push_back(encode(op_addi, 16, 16, 0, -1));
        program_mem.push_back(encode(op_bne, 0, 16, 0, -2));
        program_mem.push_back(encode(op_xor, 17, 15, 10, 0));
        program_mem.push_back(encode(op_sub, 18, 17, 0, 0));
        program_mem.push_back(encode(op_beq, 0, 0, 0, 0));
    endtask

    // architectural model that stops at the first branch to itself
    function automatic int run_reference();
        logic [xlen-1:0] model_rf [reg_count];
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] sext;
        logic [xlen-1:0] value;
        logic [4:0]      rd;
        opcode_e         op;
        logic            writes;
        logic            taken;
        logic            done;
        int              steps;
        for (int i = 0; i < reg_count; i++) begin
            model_rf[i] = '0;
        end
        pc = reset_pc;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            instr = fetch_word(pc);
            op = opcode_e'(instr[31:28]);
            rd = instr[27:23];
            a = model_rf[instr[22:18]];
            b = model_rf[instr[17:13]];
            sext = {{19{instr[12]}}, instr[12:0]};
            writes = 1'b1;
            taken = 1'b0;
            value = '0;
            case (op)
                op_add:  value = a + b;
                op_sub:  value = a - b;
                op_and:  value = a & b;
                op_or:   value = a | b;
                op_xor:  value = a ^ b;
                op_slt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                op_addi: value = a + sext;
                op_lui:  value = {instr[12:0], 19'd0};
                op_beq: begin
                    writes = 1'b0;
                    taken = (a == b);
                end
                op_bne: begin
                    writes = 1'b0;
                    taken = (a != b);
                end
                default: writes = 1'b0;
            endcase
            if (writes && rd != 5'd0) begin
                exp_pc.push_back(pc);
                exp_rd.push_back(rd);
                exp_val.push_back(value);
                model_rf[rd] = value;
            end
            if (taken && sext == '0) begin
                done = 1'b1;
            end else if (taken) begin
                pc = pc + (sext << 2);
            end else begin
                pc = pc + 32'd4;
            end
            steps++;
        end
        return exp_pc.size();
    endfunction

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    initial begin : main
        reset = 1'b1;
        imem_ack = 1'b0;
        imem_rdata = '0;
        rng_state = 32'd57;
        exp_idx = 0;
        cycle_count = 0;
        load_program();
        exp_count = run_reference();
        cycle_limit = 40 * program_mem.size() * exp_count;
        repeat (8) @(posedge aclk);
        #1 reset = 1'b0;
        wait (exp_idx == exp_count);
        // the core should now spin on its last branch with no more writes
        repeat (20) @(posedge aclk);
        $display("All tests passed!");
        $finish;
    end

    // instruction memory with random ack delay
    initial begin : memory_responder
        int delay;
        forever begin
            @(posedge aclk);
            #1;
            if (imem_req === 1'b1 && !imem_ack) begin
                delay = int'(next_random() % 6);
                repeat (delay) begin
                    @(posedge aclk);
                    #1;
                end
                imem_rdata = fetch_word(imem_addr);
                imem_ack = 1'b1;
                do begin
                    @(posedge aclk);
                    #1;
                end while (imem_req);
                imem_ack = 1'b0;
            end
        end
    end

    always @(negedge aclk) begin : compare_trace
        if (!reset && trace.wen === 1'b1) begin
            if (exp_idx >= exp_count) begin
                report_error("the core wrote a register after the program had finished");
            end else begin
                check_value("trace.pc", exp_pc[exp_idx], trace.pc);
                check_value("trace.wnum", 32'(exp_rd[exp_idx]), 32'(trace.wnum));
                check_value("trace.wdata", exp_val[exp_idx], trace.wdata);
                exp_idx++;
            end
        end
    end

    // four-phase rules at the instruction port
    always @(negedge aclk) begin : port_monitor
        if (reset) begin
            if (imem_req !== 1'b0) begin
                report_error("imem_req was not low during reset");
            end
        end else begin
            if (prev_req && imem_req && imem_addr !== prev_addr) begin
                report_error("imem_addr changed while imem_req was high");
            end
            if (prev_req && !imem_req && !prev_ack) begin
                report_error("imem_req fell before imem_ack rose");
            end
            if (!prev_req && imem_req && prev_ack) begin
                report_error("imem_req rose while imem_ack was still high");
            end
        end
        prev_req = imem_req;
        prev_ack = imem_ack;
        prev_addr = imem_addr;
    end

    always @(posedge aclk) begin : watchdog
        if (!reset) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                report_error("timeout, the trace did not finish in time");
            end
        end
    end

endmodule

// File: source/pipe_core_top.sv
`timescale 1ns/1ps

module pipe_core_top
    import core_pkg::*;
(
    input  logic            aclk,
    input  logic            reset,
    input  logic            imem_ack,
    input  logic [xlen-1:0] imem_rdata,
    output logic            imem_req,
    output logic [xlen-1:0] imem_addr,
    output trace_t          trace
);

    logic               fetch_valid;
    logic               decode_allowin;
    logic               decode_valid;
    logic               execute_allowin;
    logic               exec_valid;
    fetch_to_decode_t   fetch_out;
    decode_to_execute_t decode_out;
    execute_to_result_t exec_out;
    redirect_t          redirect;
    pending_dest_t      exec_dest;
    pending_dest_t      result_dest;
    rf_write_t          rf_write;

    fetch_unit i_fetch_unit (
        .aclk           (aclk),
        .reset          (reset),
        .redirect       (redirect),
        .decode_allowin (decode_allowin),
        .imem_ack       (imem_ack),
        .imem_rdata     (imem_rdata),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .fetch_valid    (fetch_valid),
        .fetch_out      (fetch_out)
    );

    decode_stage i_decode_stage (
        .aclk            (aclk),
        .reset           (reset),
        .fetch_valid     (fetch_valid),
        .fetch_out       (fetch_out),
        .decode_allowin  (decode_allowin),
        .execute_allowin (execute_allowin),
        .redirect        (redirect),
        .exec_dest       (exec_dest),
        .result_dest     (result_dest),
        .rf_write        (rf_write),
        .decode_valid    (decode_valid),
        .decode_out      (decode_out)
    );

    execute_stage i_execute_stage (
        .aclk            (aclk),
        .reset           (reset),
        .decode_valid    (decode_valid),
        .decode_out      (decode_out),
        .execute_allowin (execute_allowin),
        .exec_valid      (exec_valid),
        .exec_out        (exec_out),
        .exec_dest       (exec_dest),
        .redirect        (redirect)
    );

    result_stage i_result_stage (
        .aclk        (aclk),
        .reset       (reset),
        .exec_valid  (exec_valid),
        .exec_out    (exec_out),
        .result_dest (result_dest),
        .rf_write    (rf_write),
        .trace       (trace)
    );

endmodule

// File: source/result_stage.sv
`timescale 1ns/1ps

module result_stage
    import core_pkg::*;
(
    input  logic               aclk,
    input  logic               reset,
    input  logic               exec_valid,
    input  execute_to_result_t exec_out,
    output pending_dest_t      result_dest,
    output rf_write_t          rf_write,
    output trace_t             trace
);

    execute_to_result_t rs_item;
    logic               rs_valid;
    logic               write_en;

    always_ff @(posedge aclk) begin
        if (reset) begin
            rs_valid <= 1'b0;
        end else begin
            rs_valid <= exec_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (exec_valid) begin
            rs_item <= exec_out;
        end
    end

    // no write and no trace for r0
    assign write_en = rs_valid && rs_item.wen && (rs_item.rd != '0);

    assign rf_write.we   = write_en;
    assign rf_write.addr = rs_item.rd;
    assign rf_write.data = rs_item.value;

    assign trace.pc    = rs_item.pc;
    assign trace.wen   = write_en;
    assign trace.wnum  = rs_item.rd;
    assign trace.wdata = rs_item.value;

    assign result_dest.valid = rs_valid && rs_item.wen;
    assign result_dest.rd    = rs_item.rd;

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
(
    input  logic               aclk,
    input  logic               reset,
    input  logic               decode_valid,
    input  decode_to_execute_t decode_out,
    output logic               execute_allowin,
    output logic               exec_valid,
    output execute_to_result_t exec_out,
    output pending_dest_t      exec_dest,
    output redirect_t          redirect
);

    decode_to_execute_t es_item;
    logic [xlen-1:0]    alu_result;
    logic               taken;

    // result stage never stalls
    assign execute_allowin = 1'b1;

    always_ff @(posedge aclk) begin
        if (reset) begin
            exec_valid <= 1'b0;
        end else if (execute_allowin) begin
            exec_valid <= decode_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (decode_valid && execute_allowin) begin
            es_item <= decode_out;
        end
    end

    always_comb begin
        alu_result = '0;
        taken      = 1'b0;
        case (es_item.opcode)
            op_add, op_addi: alu_result = es_item.src_a + es_item.src_b;
            op_sub:  alu_result = es_item.src_a - es_item.src_b;
            op_and:  alu_result = es_item.src_a & es_item.src_b;
            op_or:   alu_result = es_item.src_a | es_item.src_b;
            op_xor:  alu_result = es_item.src_a ^ es_item.src_b;
            op_slt:  alu_result = {{(xlen-1){1'b0}},
                                   $signed(es_item.src_a) < $signed(es_item.src_b)};
            op_lui:  alu_result = {es_item.imm[imm_w-1:0], {(xlen-imm_w){1'b0}}};
            op_beq:  taken = (es_item.src_a == es_item.src_b);
            op_bne:  taken = (es_item.src_a != es_item.src_b);
            default: ;
        endcase
    end

    // branch offset counts words
    assign redirect.valid  = exec_valid && taken;
    assign redirect.target = es_item.pc + {es_item.imm[xlen-3:0], 2'b00};

    assign exec_out.pc    = es_item.pc;
    assign exec_out.rd    = es_item.rd;
    assign exec_out.value = alu_result;
    assign exec_out.wen   = es_item.wen;

    assign exec_dest.valid = exec_valid && es_item.wen;
    assign exec_dest.rd    = es_item.rd;

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
(
    input  logic               aclk,
    input  logic               reset,
    input  logic               fetch_valid,
    input  fetch_to_decode_t   fetch_out,
    output logic               decode_allowin,
    input  logic               execute_allowin,
    input  redirect_t          redirect,
    input  pending_dest_t      exec_dest,
    input  pending_dest_t      result_dest,
    input  rf_write_t          rf_write,
    output logic               decode_valid,
    output decode_to_execute_t decode_out
);

    fetch_to_decode_t      ds_item;
    logic                  ds_valid;
    opcode_e               op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rk;
    logic [imm_w-1:0]      imm;
    logic [xlen-1:0]       imm_sext;
    logic [xlen-1:0]       rj_value;
    logic [xlen-1:0]       rk_value;
    logic                  uses_rj;
    logic                  uses_rk;
    logic                  writes_rd;
    logic                  hazard;
    logic [xlen-1:0]       rf [reg_count];

    function automatic logic dest_hit(input pending_dest_t dest,
                                      input logic [reg_addr_w-1:0] src);
        return dest.valid && (src != '0) && (dest.rd == src);
    endfunction

    assign op       = opcode_e'(ds_item.instr[xlen-1 -: $bits(opcode_e)]);
    assign rd       = ds_item.instr[imm_w + 2*reg_addr_w +: reg_addr_w];
    assign rj       = ds_item.instr[imm_w + reg_addr_w +: reg_addr_w];
    assign rk       = ds_item.instr[imm_w +: reg_addr_w];
    assign imm      = ds_item.instr[imm_w-1:0];
    assign imm_sext = {{(xlen-imm_w){imm[imm_w-1]}}, imm};

    always_comb begin
        uses_rj   = 1'b0;
        uses_rk   = 1'b0;
        writes_rd = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
                uses_rj   = 1'b1;
                uses_rk   = 1'b1;
                writes_rd = 1'b1;
            end
            op_addi: begin
                uses_rj   = 1'b1;
                writes_rd = 1'b1;
            end
            op_lui: writes_rd = 1'b1;
            op_beq, op_bne: begin
                uses_rj = 1'b1;
                uses_rk = 1'b1;
            end
            default: ;
        endcase
    end

    // raw hazard on anything still in execute or result
    assign hazard = (uses_rj && (dest_hit(exec_dest, rj) || dest_hit(result_dest, rj)))
                 || (uses_rk && (dest_hit(exec_dest, rk) || dest_hit(result_dest, rk)));

    assign decode_allowin = !ds_valid || (!hazard && execute_allowin);
    assign decode_valid   = ds_valid && !hazard && !redirect.valid;

    always_ff @(posedge aclk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (redirect.valid) begin
            ds_valid <= 1'b0;
        end else if (decode_allowin) begin
            ds_valid <= fetch_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (fetch_valid && decode_allowin) begin
            ds_item <= fetch_out;
        end
    end

    // r0 is never written
    always_ff @(posedge aclk) begin
        if (rf_write.we && (rf_write.addr != '0)) begin
            rf[rf_write.addr] <= rf_write.data;
        end
    end

    assign rj_value = (rj == '0) ? '0 : rf[rj];
    assign rk_value = (rk == '0) ? '0 : rf[rk];

    always_comb begin
        decode_out.pc     = ds_item.pc;
        decode_out.opcode = op;
        decode_out.rd     = rd;
        decode_out.src_a  = rj_value;
        decode_out.src_b  = (op == op_addi) ? imm_sext : rk_value;
        decode_out.imm    = imm_sext;
        decode_out.wen    = writes_rd;
    end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import core_pkg::*;
(
    input  logic             aclk,
    input  logic             reset,
    input  redirect_t        redirect,
    input  logic             decode_allowin,
    input  logic             imem_ack,
    input  logic [xlen-1:0]  imem_rdata,
    output logic             imem_req,
    output logic [xlen-1:0]  imem_addr,
    output logic             fetch_valid,
    output fetch_to_decode_t fetch_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_release
    } fetch_state_e;

    fetch_state_e    state;
    logic [xlen-1:0] pc;
    logic            discard;
    logic            issue;
    logic            capture;

    // start a request once the buffer is free or about to be
    assign issue   = (state == st_idle) && (!fetch_valid || decode_allowin || redirect.valid);
    assign capture = (state == st_wait_ack) && imem_ack;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= st_idle;
            imem_req  <= 1'b0;
            imem_addr <= reset_pc;
            discard   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (issue) begin
                        imem_req  <= 1'b1;
                        imem_addr <= redirect.valid ? redirect.target : pc;
                        state     <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (imem_ack) begin
                        imem_req <= 1'b0;
                        discard  <= 1'b0;
                        state    <= st_wait_release;
                    end else if (redirect.valid) begin
                        // stale fetch, finish the handshake and drop the word
                        discard <= 1'b1;
                    end
                end
                st_wait_release: begin
                    if (!imem_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // next address to fetch
    always_ff @(posedge aclk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else if (capture && !discard) begin
            pc <= imem_addr + xlen'(4);
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else if (redirect.valid) begin
            fetch_valid <= 1'b0;
        end else if (capture && !discard) begin
            fetch_valid <= 1'b1;
        end else if (decode_allowin) begin
            fetch_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (capture) begin
            fetch_out.pc    <= imem_addr;
            fetch_out.instr <= imem_rdata;
        end
    end

endmodule

// File: source/core_pkg.sv
package core_pkg;

    // machine widths
    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 13;

    localparam logic [xlen-1:0] reset_pc = '0;

    // instruction word, msb first
    // opcode[31:28] rd[27:23] rj[22:18] rk[17:13] imm[12:0]
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_slt  = 4'd5,
        op_addi = 4'd6,
        op_lui  = 4'd7,
        op_beq  = 4'd8,
        op_bne  = 4'd9
    } opcode_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_to_decode_t;

    // operands already read, src_b already muxed
    typedef struct packed {
        logic [xlen-1:0]       pc;
        opcode_e               opcode;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       src_a;
        logic [xlen-1:0]       src_b;
        logic [xlen-1:0]       imm;
        logic                  wen;
    } decode_to_execute_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
        logic                  wen;
    } execute_to_result_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } rf_write_t;

    // destination still in flight, seen by the interlock
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
    } pending_dest_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic                  wen;
        logic [reg_addr_w-1:0] wnum;
        logic [xlen-1:0]       wdata;
    } trace_t;

endpackage
